// File: source/prf_pkg.sv
// ------------------------------------------------------------------
// sizes and bus types shared by the banked physical register file
// every design file and the testbench import this package
// ------------------------------------------------------------------
package prf_pkg;

    // register file geometry
    localparam int PR_COUNT   = 64;
    localparam int BANK_COUNT = 4;
    localparam int PR_BITS    = $clog2(PR_COUNT);
    localparam int BANK_BITS  = $clog2(BANK_COUNT);
    localparam int UPPER_BITS = PR_BITS - BANK_BITS;

    // requester counts
    localparam int RR_COUNT = 4;
    localparam int WR_COUNT = 3;

    localparam int DATA_BITS = 32;
    localparam int ROB_BITS  = 6;

    // register number as index within bank over bank select
    typedef struct packed {
        logic [UPPER_BITS-1:0] upper;
        logic [BANK_BITS-1:0]  bank;
    } pr_split_t;

    typedef union packed {
        logic [PR_BITS-1:0] flat;
        pr_split_t          split;
    } pr_u;

    // ------------------------------------------------------------------
    // request and broadcast buses

    typedef struct packed {
        logic valid;
        pr_u  pr;
    } rd_req_t;

    typedef struct packed {
        logic ack;
        logic port;
    } rd_resp_t;

    typedef struct packed {
        logic                 valid;
        logic [DATA_BITS-1:0] data;
        pr_u                  pr;
        logic [ROB_BITS-1:0]  rob;
    } wb_req_t;

    typedef struct packed {
        logic                  valid;
        logic [UPPER_BITS-1:0] upper;
    } wb_bus_t;

    typedef struct packed {
        logic                valid;
        logic [ROB_BITS-1:0] rob;
    } cmpl_bus_t;

    // write command into one bank
    typedef struct packed {
        logic                  en;
        logic [UPPER_BITS-1:0] upper;
        logic [DATA_BITS-1:0]  data;
    } ram_wr_t;

endpackage

// File: source/rotating_picker.sv
// ------------------------------------------------------------------
// one-hot round robin pick for one bank
// grants the lowest request inside the rotation mask, else the lowest
// request overall; narrower users tie the upper request bits low
// ------------------------------------------------------------------
`timescale 1ns/10ps

module rotating_picker import prf_pkg::*; (
    input  logic [RR_COUNT-1:0] req,
    input  logic [RR_COUNT-1:0] mask,
    output logic [RR_COUNT-1:0] grant
);

    logic [RR_COUNT-1:0] masked_req;
    logic [RR_COUNT-1:0] masked_pick;
    logic [RR_COUNT-1:0] unmasked_pick;

    // one-hot lowest set bit of a vector
    function automatic logic [RR_COUNT-1:0] lowest_bit(input logic [RR_COUNT-1:0] vec);
        logic [RR_COUNT-1:0] pick;
        logic                found;
        pick  = '0;
        found = 1'b0;
        for (int i = 0; i < RR_COUNT; i++) begin
            if (vec[i] && !found) begin
                pick[i] = 1'b1;
                found   = 1'b1;
            end
        end
        return pick;
    endfunction

    // requests above the previous winner
    assign masked_req = req & mask;

    always_comb begin
        masked_pick   = lowest_bit(masked_req);
        unmasked_pick = lowest_bit(req);
    end

    // wrap around to the bottom when nothing is left above the mask
    always_comb begin
        if (|masked_req) begin
            grant = masked_pick;
        end
        else begin
            grant = unmasked_pick;
        end
    end

endmodule

// File: source/prf_bank_ram.sv
// ------------------------------------------------------------------
// storage for one register bank
// two combinational read ports addressed by registered indexes,
// one write port taken on the clock edge
// ------------------------------------------------------------------
`timescale 1ns/10ps

module prf_bank_ram import prf_pkg::*; (
    input  logic                  CLK,
    input  logic [UPPER_BITS-1:0] rd_index0,
    input  logic [UPPER_BITS-1:0] rd_index1,
    output logic [DATA_BITS-1:0]  rd_data0,
    output logic [DATA_BITS-1:0]  rd_data1,
    input  ram_wr_t               wr
);

    logic [DATA_BITS-1:0] mem [(1 << UPPER_BITS)];

    // contents start at zero so register 0 reads as zero
    initial begin
        for (int i = 0; i < (1 << UPPER_BITS); i++) begin
            mem[i] = '0;
        end
    end

    // write port
    always_ff @(posedge CLK) begin
        if (wr.en) begin
            mem[wr.upper] <= wr.data;
        end
    end

    // a write on this edge reaches the read ports right after it
    assign rd_data0 = mem[rd_index0];
    assign rd_data1 = mem[rd_index1];

endmodule

// File: source/read_arbiter.sv
// ------------------------------------------------------------------
// read port arbitration for all banks
// merges new pulses with held losers, grants two reads per bank and
// registers the bank read indexes together with the responses
// ------------------------------------------------------------------
`timescale 1ns/10ps

module read_arbiter import prf_pkg::*; (
    input  logic                                        CLK,
    input  logic                                        nRST,
    input  rd_req_t  [RR_COUNT-1:0]                     rd_req,
    output rd_resp_t [RR_COUNT-1:0]                     rd_resp,
    output logic [BANK_COUNT-1:0][1:0][UPPER_BITS-1:0] rd_index
);

    // ------------------------------------------------------------------
    // signals

    // losers waiting for a port
    logic [RR_COUNT-1:0] held_valid;
    pr_u  [RR_COUNT-1:0] held_pr;
    logic [RR_COUNT-1:0] next_held_valid;

    // held request if any, else the new pulse
    logic [RR_COUNT-1:0] cur_valid;
    pr_u  [RR_COUNT-1:0] cur_pr;

    logic [BANK_COUNT-1:0][RR_COUNT-1:0] bank_req;
    logic [BANK_COUNT-1:0][RR_COUNT-1:0] port0_grant;
    logic [BANK_COUNT-1:0][RR_COUNT-1:0] port1_grant;
    logic [BANK_COUNT-1:0][RR_COUNT-1:0] last_mask;
    logic [BANK_COUNT-1:0][RR_COUNT-1:0] next_last_mask;

    rd_resp_t [RR_COUNT-1:0]                     next_rd_resp;
    logic [BANK_COUNT-1:0][1:0][UPPER_BITS-1:0] next_rd_index;

    // ------------------------------------------------------------------
    // merge and sort into banks

    always_comb begin
        bank_req = '0;
        for (int rr = 0; rr < RR_COUNT; rr++) begin
            cur_valid[rr] = held_valid[rr] | rd_req[rr].valid;
            cur_pr[rr]    = held_valid[rr] ? held_pr[rr] : rd_req[rr].pr;
            bank_req[cur_pr[rr].split.bank][rr] = cur_valid[rr];
        end
    end

    // port 1 picks among what port 0 left over
    for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank
        rotating_picker port0_pick_i (
            .req   (bank_req[b]),
            .mask  (last_mask[b]),
            .grant (port0_grant[b])
        );

        rotating_picker port1_pick_i (
            .req   (bank_req[b] & ~port0_grant[b]),
            .mask  (last_mask[b]),
            .grant (port1_grant[b])
        );
    end

    // ------------------------------------------------------------------
    // responses, indexes and rotation

    always_comb begin
        next_rd_resp   = '0;
        next_rd_index  = '0;
        next_last_mask = '0;
        for (int b = 0; b < BANK_COUNT; b++) begin
            for (int rr = 0; rr < RR_COUNT; rr++) begin
                next_rd_resp[rr].ack  |= port0_grant[b][rr] | port1_grant[b][rr];
                next_rd_resp[rr].port |= port1_grant[b][rr];
                // one-hot mux of the winners' upper index
                next_rd_index[b][0] |= cur_pr[rr].split.upper
                                       & {UPPER_BITS{port0_grant[b][rr]}};
                next_rd_index[b][1] |= cur_pr[rr].split.upper
                                       & {UPPER_BITS{port1_grant[b][rr]}};
            end
            // everything above the port 1 winner
            for (int rr = 1; rr < RR_COUNT; rr++) begin
                next_last_mask[b][rr] = next_last_mask[b][rr-1] | port1_grant[b][rr-1];
            end
        end
        for (int rr = 0; rr < RR_COUNT; rr++) begin
            next_held_valid[rr] = cur_valid[rr] & ~next_rd_resp[rr].ack;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            held_valid <= '0;
            held_pr    <= '0;
            last_mask  <= '0;
            rd_resp    <= '0;
            rd_index   <= '0;
        end
        else begin
            held_valid <= next_held_valid;
            held_pr    <= cur_pr;
            last_mask  <= next_last_mask;
            rd_resp    <= next_rd_resp;
            rd_index   <= next_rd_index;
        end
    end

endmodule

// File: source/wb_arbiter.sv
// ------------------------------------------------------------------
// writeback arbitration for all banks
// keeps one unacked writeback per requester, grants one per bank and
// drives the bank writes, writeback, completion and forward buses
// ------------------------------------------------------------------
`timescale 1ns/10ps

module wb_arbiter import prf_pkg::*; (
    input  logic                                 CLK,
    input  logic                                 nRST,
    input  wb_req_t   [WR_COUNT-1:0]             wb_req,
    output logic      [WR_COUNT-1:0]             wb_ready,
    output ram_wr_t   [BANK_COUNT-1:0]           ram_wr,
    output wb_bus_t   [BANK_COUNT-1:0]           wb_bus,
    output cmpl_bus_t [BANK_COUNT-1:0]           cmpl_bus,
    output logic      [BANK_COUNT-1:0][DATA_BITS-1:0] fwd_data
);

    // ------------------------------------------------------------------
    // signals

    wb_req_t [WR_COUNT-1:0] held;
    wb_req_t [WR_COUNT-1:0] next_held;
    wb_req_t [WR_COUNT-1:0] cur;

    logic [BANK_COUNT-1:0][WR_COUNT-1:0] bank_req;
    logic [BANK_COUNT-1:0][RR_COUNT-1:0] pick_grant;
    logic [BANK_COUNT-1:0][WR_COUNT-1:0] grant;
    logic [BANK_COUNT-1:0][WR_COUNT-1:0] last_mask;
    logic [BANK_COUNT-1:0][WR_COUNT-1:0] next_last_mask;
    logic [WR_COUNT-1:0]                 ack;

    pr_u       [BANK_COUNT-1:0] win_pr;
    ram_wr_t   [BANK_COUNT-1:0] next_ram_wr;
    cmpl_bus_t [BANK_COUNT-1:0] next_cmpl;

    // ------------------------------------------------------------------
    // merge and sort into banks

    // a new request is only taken while nothing is held for it
    always_comb begin
        bank_req = '0;
        for (int wr = 0; wr < WR_COUNT; wr++) begin
            cur[wr] = held[wr].valid ? held[wr] : wb_req[wr];
            bank_req[cur[wr].pr.split.bank][wr] = cur[wr].valid;
            wb_ready[wr] = ~held[wr].valid;
        end
    end

    for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank
        rotating_picker pick_i (
            .req   (RR_COUNT'(bank_req[b])),
            .mask  (RR_COUNT'(last_mask[b])),
            .grant (pick_grant[b])
        );

        assign grant[b] = pick_grant[b][WR_COUNT-1:0];

        // writeback bus mirrors the bank write
        assign wb_bus[b].valid = ram_wr[b].en;
        assign wb_bus[b].upper = ram_wr[b].upper;
    end

    // ------------------------------------------------------------------
    // winner mux, held losers and rotation

    always_comb begin
        ack            = '0;
        win_pr         = '0;
        next_ram_wr    = '0;
        next_cmpl      = '0;
        next_last_mask = '0;
        for (int b = 0; b < BANK_COUNT; b++) begin
            ack |= grant[b];
            next_cmpl[b].valid = |bank_req[b];
            for (int wr = 0; wr < WR_COUNT; wr++) begin
                win_pr[b].flat      |= cur[wr].pr.flat & {PR_BITS{grant[b][wr]}};
                next_ram_wr[b].data |= cur[wr].data & {DATA_BITS{grant[b][wr]}};
                next_cmpl[b].rob    |= cur[wr].rob & {ROB_BITS{grant[b][wr]}};
            end
            next_ram_wr[b].upper = win_pr[b].split.upper;
            // register 0 stays zero while its completion still goes out
            next_ram_wr[b].en = next_cmpl[b].valid && (win_pr[b].flat != '0);
            for (int wr = 1; wr < WR_COUNT; wr++) begin
                next_last_mask[b][wr] = next_last_mask[b][wr-1] | grant[b][wr-1];
            end
        end
        next_held = cur;
        for (int wr = 0; wr < WR_COUNT; wr++) begin
            next_held[wr].valid = cur[wr].valid & ~ack[wr];
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            held      <= '0;
            last_mask <= '0;
            ram_wr    <= '0;
            cmpl_bus  <= '0;
            fwd_data  <= '0;
        end
        else begin
            held      <= next_held;
            last_mask <= next_last_mask;
            ram_wr    <= next_ram_wr;
            cmpl_bus  <= next_cmpl;
            // data shows up the cycle after the bank write
            for (int b = 0; b < BANK_COUNT; b++) begin
                fwd_data[b] <= ram_wr[b].data;
            end
        end
    end

endmodule

// File: source/prf_top.sv
// ------------------------------------------------------------------
// banked physical register file, top level
// read and writeback arbiters in front of one storage block per bank
// ------------------------------------------------------------------
`timescale 1ns/10ps

module prf_top import prf_pkg::*; (
    input  logic                                       CLK,
    input  logic                                       nRST,

    // reads
    input  rd_req_t   [RR_COUNT-1:0]                   rd_req,
    output rd_resp_t  [RR_COUNT-1:0]                   rd_resp,
    output logic [BANK_COUNT-1:0][1:0][DATA_BITS-1:0] rd_data,

    // writebacks
    input  wb_req_t   [WR_COUNT-1:0]                   wb_req,
    output logic      [WR_COUNT-1:0]                   wb_ready,

    // per bank broadcasts
    output wb_bus_t   [BANK_COUNT-1:0]                 wb_bus,
    output cmpl_bus_t [BANK_COUNT-1:0]                 cmpl_bus,
    output logic      [BANK_COUNT-1:0][DATA_BITS-1:0]  fwd_data
);

    logic [BANK_COUNT-1:0][1:0][UPPER_BITS-1:0] rd_index;
    ram_wr_t [BANK_COUNT-1:0]                    ram_wr;

    read_arbiter read_arb_i (
        .CLK      (CLK),
        .nRST     (nRST),
        .rd_req   (rd_req),
        .rd_resp  (rd_resp),
        .rd_index (rd_index)
    );

    wb_arbiter wb_arb_i (
        .CLK      (CLK),
        .nRST     (nRST),
        .wb_req   (wb_req),
        .wb_ready (wb_ready),
        .ram_wr   (ram_wr),
        .wb_bus   (wb_bus),
        .cmpl_bus (cmpl_bus),
        .fwd_data (fwd_data)
    );

    // one storage block per bank
    for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank
        prf_bank_ram bank_ram_i (
            .CLK       (CLK),
            .rd_index0 (rd_index[b][0]),
            .rd_index1 (rd_index[b][1]),
            .rd_data0  (rd_data[b][0]),
            .rd_data1  (rd_data[b][1]),
            .wr        (ram_wr[b])
        );
    end

endmodule

// File: test/tb_clock.sv
// ------------------------------------------------------------------
// clock and reset for the register file testbench
// 4 ns clock, reset held low for the first two cycles
// ------------------------------------------------------------------
`timescale 1ns/10ps

module tb_clock (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK  = 1'b0;
        nRST = 1'b0;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
    end

    always #2 CLK = ~CLK;

endmodule

// File: test/prf_tb.sv
// ------------------------------------------------------------------
// testbench for the banked register file
// applies a table of read and writeback steps, keeps a register model
// and checks every response and broadcast once per cycle
// ------------------------------------------------------------------
`timescale 1ns/10ps

module prf_tb import prf_pkg::*; ();

    localparam int STEP_TIMEOUT = 20;
    localparam int WAIT_TIMEOUT = 20;

    typedef struct {
        bit                               is_read;
        logic [RR_COUNT-1:0]              active;
        logic [RR_COUNT-1:0][PR_BITS-1:0] pr;
        int                               exp_cycles;
        int                               exp_first;
    } step_t;

    logic                                       CLK;
    logic                                       nRST;
    rd_req_t   [RR_COUNT-1:0]                   rd_req;
    rd_resp_t  [RR_COUNT-1:0]                   rd_resp;
    logic [BANK_COUNT-1:0][1:0][DATA_BITS-1:0] rd_data;
    wb_req_t   [WR_COUNT-1:0]                   wb_req;
    logic      [WR_COUNT-1:0]                   wb_ready;
    wb_bus_t   [BANK_COUNT-1:0]                 wb_bus;
    cmpl_bus_t [BANK_COUNT-1:0]                 cmpl_bus;
    logic      [BANK_COUNT-1:0][DATA_BITS-1:0]  fwd_data;

    // register model and per step bookkeeping
    logic [DATA_BITS-1:0]                 model [PR_COUNT];
    step_t                                steps [$];
    int                                   seed;
    logic [RR_COUNT-1:0]                  rd_pending;
    logic [RR_COUNT-1:0]                  rd_done;
    pr_u  [RR_COUNT-1:0]                  rd_pr;
    logic [WR_COUNT-1:0]                  wb_pending;
    logic [WR_COUNT-1:0]                  wb_done;
    pr_u  [WR_COUNT-1:0]                  wb_pr;
    logic [WR_COUNT-1:0][ROB_BITS-1:0]    wb_rob;
    logic [WR_COUNT-1:0][DATA_BITS-1:0]   wb_data;
    logic [BANK_COUNT-1:0]                fwd_pending;
    logic [BANK_COUNT-1:0][DATA_BITS-1:0] fwd_expect;

    tb_clock clock_i (
        .CLK  (CLK),
        .nRST (nRST)
    );

    prf_top dut_i (.*);

    // ------------------------------------------------------------------
    // failure and compare tasks

    task automatic stop_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic fail_run(input string msg);
        $display("%s at %0t ns", msg, $time);
        stop_run();
    endtask

    task automatic check_data(input string name, input logic [DATA_BITS-1:0] got,
                              input logic [DATA_BITS-1:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_resp(input string name, input rd_resp_t got, input rd_resp_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_wb_bus(input string name, input wb_bus_t got, input wb_bus_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_cmpl(input string name, input cmpl_bus_t got, input cmpl_bus_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_ready(input string name, input logic [WR_COUNT-1:0] got,
                               input logic [WR_COUNT-1:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_reset_state();
        for (int i = 0; i < BANK_COUNT; i++) begin
            check_wb_bus($sformatf("wb_bus[%0d]", i), wb_bus[i], '0);
            check_cmpl($sformatf("cmpl_bus[%0d]", i), cmpl_bus[i], '0);
            check_data($sformatf("fwd_data[%0d]", i), fwd_data[i], '0);
            check_data($sformatf("rd_data[%0d][0]", i), rd_data[i][0], '0);
            check_data($sformatf("rd_data[%0d][1]", i), rd_data[i][1], '0);
        end
        for (int r = 0; r < RR_COUNT; r++) begin
            check_resp($sformatf("rd_resp[%0d]", r), rd_resp[r], '0);
        end
        check_ready("wb_ready", wb_ready, '1);
    endtask

    // ------------------------------------------------------------------
    // every output checked once per cycle after the falling edge

    task automatic tick();
        logic [BANK_COUNT-1:0][1:0] port_used;
        int                         acks [BANK_COUNT];
        int                         last_rr [BANK_COUNT];
        int                         b;
        int                         hit;
        wb_bus_t                    exp_bus;
        rd_resp_t                   exp_resp;
        @(negedge CLK);
        port_used = '0;
        for (int i = 0; i < BANK_COUNT; i++) begin
            acks[i]    = 0;
            last_rr[i] = 0;
            // forward bus trails the bank write by one cycle
            if (fwd_pending[i]) begin
                check_data($sformatf("fwd_data[%0d]", i), fwd_data[i], fwd_expect[i]);
            end
        end
        fwd_pending = '0;
        for (int i = 0; i < BANK_COUNT; i++) begin
            hit = -1;
            for (int w = 0; w < WR_COUNT; w++) begin
                if (cmpl_bus[i].valid && wb_pending[w] && !wb_done[w]
                    && wb_rob[w] == cmpl_bus[i].rob && wb_pr[w].split.bank == BANK_BITS'(i)) begin
                    hit = w;
                end
            end
            if (cmpl_bus[i].valid && hit < 0) begin
                fail_run($sformatf("unexpected completion of rob %0d on bank %0d",
                                   cmpl_bus[i].rob, i));
            end
            if (hit < 0) begin
                check_cmpl($sformatf("cmpl_bus[%0d]", i), cmpl_bus[i], '0);
                check_wb_bus($sformatf("wb_bus[%0d]", i), wb_bus[i], '0);
            end
            else begin
                wb_done[hit] = 1'b1;
                // register 0 completes without a writeback
                exp_bus.valid = (wb_pr[hit].flat != '0);
                exp_bus.upper = wb_pr[hit].split.upper;
                check_wb_bus($sformatf("wb_bus[%0d]", i), wb_bus[i], exp_bus);
                if (exp_bus.valid) begin
                    model[wb_pr[hit].flat] = wb_data[hit];
                    fwd_pending[i]         = 1'b1;
                    fwd_expect[i]          = wb_data[hit];
                end
            end
        end
        // low exactly while a writeback is held
        check_ready("wb_ready", wb_ready, ~(wb_pending & ~wb_done));
        for (int r = 0; r < RR_COUNT; r++) begin
            if (!rd_resp[r].ack) begin
                check_resp($sformatf("rd_resp[%0d]", r), rd_resp[r], '0);
            end
            else if (!rd_pending[r] || rd_done[r]) begin
                fail_run($sformatf("read requester %0d acked without a request", r));
            end
            else begin
                b = int'(rd_pr[r].split.bank);
                if (port_used[b][rd_resp[r].port]) begin
                    fail_run($sformatf("two reads of bank %0d on one port", b));
                end
                port_used[b][rd_resp[r].port] = 1'b1;
                acks[b]++;
                last_rr[b] = r;
                rd_done[r] = 1'b1;
                check_data($sformatf("rd_data[%0d][%0d]", b, rd_resp[r].port),
                           rd_data[b][rd_resp[r].port], model[rd_pr[r].flat]);
            end
        end
        // a lone winner in its bank always gets port 0
        exp_resp.ack  = 1'b1;
        exp_resp.port = 1'b0;
        for (int i = 0; i < BANK_COUNT; i++) begin
            if (acks[i] == 1) begin
                check_resp($sformatf("rd_resp[%0d]", last_rr[i]), rd_resp[last_rr[i]], exp_resp);
            end
        end
    endtask

    // ------------------------------------------------------------------
    // step table and its driver

    task automatic add_step(input bit is_read, input logic [RR_COUNT-1:0] active,
                            input int pr0, input int pr1, input int pr2, input int pr3,
                            input int exp_cycles, input int exp_first);
        step_t st;
        st.is_read    = is_read;
        st.active     = active;
        st.pr[0]      = PR_BITS'(pr0);
        st.pr[1]      = PR_BITS'(pr1);
        st.pr[2]      = PR_BITS'(pr2);
        st.pr[3]      = PR_BITS'(pr3);
        st.exp_cycles = exp_cycles;
        st.exp_first  = exp_first;
        steps.push_back(st);
    endtask

    function automatic bit step_done(input bit is_read);
        if (is_read) begin
            return rd_done == rd_pending;
        end
        return wb_done == wb_pending;
    endfunction

    task automatic run_step(input step_t st, input int idx);
        int cycles;
        int waited;
        waited = 0;
        while (wb_ready !== '1) begin
            if (waited >= WAIT_TIMEOUT) begin
                fail_run("wb_ready did not return high");
            end
            tick();
            waited++;
        end
        rd_pending = '0;
        rd_done    = '0;
        wb_pending = '0;
        wb_done    = '0;
        for (int r = 0; r < RR_COUNT; r++) begin
            rd_pr[r].flat = st.pr[r];
            if (st.is_read && st.active[r]) begin
                rd_pending[r] = 1'b1;
                rd_req[r]     = '{valid: 1'b1, pr: rd_pr[r]};
            end
        end
        for (int w = 0; w < WR_COUNT; w++) begin
            if (!st.is_read && st.active[w]) begin
                wb_pending[w]    = 1'b1;
                wb_pr[w].flat    = st.pr[w];
                wb_rob[w]        = ROB_BITS'(idx * 4 + w);
                wb_data[w]       = DATA_BITS'($random(seed));
                wb_req[w].valid  = 1'b1;
                wb_req[w].data   = wb_data[w];
                wb_req[w].pr     = wb_pr[w];
                wb_req[w].rob    = wb_rob[w];
            end
        end
        tick();
        // reads are pulses and writebacks were taken while wb_ready was high
        rd_req = '0;
        wb_req = '0;
        cycles = 1;
        if (st.exp_first >= 0 && !wb_done[st.exp_first]) begin
            fail_run($sformatf("step %0d: requester %0d did not win first", idx, st.exp_first));
        end
        while (!step_done(st.is_read)) begin
            if (cycles >= STEP_TIMEOUT) begin
                fail_run($sformatf("step %0d did not finish within %0d cycles", idx, cycles));
            end
            tick();
            cycles++;
        end
        if (cycles != st.exp_cycles) begin
            fail_run($sformatf("step %0d took %0d cycles instead of %0d", idx, cycles,
                               st.exp_cycles));
        end
    endtask

    initial begin
        int waited;
        seed        = 54;
        waited      = 0;
        rd_req      = '0;
        wb_req      = '0;
        rd_pending  = '0;
        rd_done     = '0;
        wb_pending  = '0;
        wb_done     = '0;
        fwd_pending = '0;
        for (int i = 0; i < PR_COUNT; i++) begin
            model[i] = '0;
        end
        // step columns are read, active requesters, pr of requesters 0 to 3,
        // cycles and first winner
        add_step(1'b0, 4'b0001,  5,  0,  0,  0, 1,  0);
        add_step(1'b0, 4'b0010,  0,  0,  0,  0, 1,  1);
        add_step(1'b1, 4'b0011,  5,  0,  0,  0, 1, -1);
        // three writebacks to bank 0, then four reads of it
        add_step(1'b0, 4'b0111,  8, 12, 20,  0, 3,  0);
        add_step(1'b1, 4'b1111,  8, 12, 20,  0, 2, -1);
        add_step(1'b0, 4'b0111,  2,  7, 13,  0, 1,  0);
        add_step(1'b1, 4'b1111,  8, 13,  2,  7, 1, -1);
        add_step(1'b0, 4'b0111, 63,  3,  7,  0, 3,  0);
        add_step(1'b1, 4'b1111, 63,  3,  7,  7, 2, -1);
        add_step(1'b1, 4'b1111,  5, 20, 63,  0, 1, -1);
        while (nRST !== 1'b1) begin
            if (waited >= WAIT_TIMEOUT) begin
                fail_run("reset was never released");
            end
            @(posedge CLK);
            waited++;
        end
        @(negedge CLK);
        check_reset_state();
        foreach (steps[s]) begin
            run_step(steps[s], s);
            // idle cycles let the forward bus and rotation settle
            tick();
            tick();
        end
        $display("Everything OK");
        $finish;
    end

endmodule

// File: files.f
source/prf_pkg.sv
source/rotating_picker.sv
source/prf_bank_ram.sv
source/read_arbiter.sv
source/wb_arbiter.sv
source/prf_top.sv
test/tb_clock.sv
test/prf_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the register file testbench with Verilator and run it,
# the run passes only when the pass message shows up in the output
verilator --binary --timing --top-module prf_tb -f files.f -o prf_sim \
    && ./obj_dir/prf_sim | tee /dev/stderr | grep -q "Everything OK" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
